//--- adc_display.f
+incdir+verilog
verilog/disp_num_pkg.sv
verilog/seg_glyph_pkg.sv
verilog/pipe_slice.sv
verilog/bin_to_bcd.sv
verilog/digit_format.sv
verilog/seg_scan.sv
verilog/adc_display_top.sv
bench/adc_display_assert.sv
bench/adc_display_tb.sv

//--- bench/adc_display_assert.sv
/*
 * concurrent checks on the display top, bound into it
 */
`default_nettype none

`include "disp_settings.svh"

module adc_display_assert
	import disp_num_pkg::*;
	import seg_glyph_pkg::*;
(
	input logic                    sys_clk,
	input logic                    sys_rst_n,
	input logic                    sample_valid,
	input logic                    sample_ready,
	input sample_t                 sample_data,
	input seg_pattern_t            seg_number,
	input logic [`DISP_DIGITS-1:0] seg_choice
);

	// exactly one digit driven at a time
	one_digit_selected: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$countones(~seg_choice) == 1)
		else $error("seg_choice 0x%h does not select exactly one digit", seg_choice);

	dp_dark: assert property (@(posedge sys_clk) disable iff (!sys_rst_n) seg_number[7])
		else $error("decimal point segment driven on");

	// an offer waiting for ready keeps its value
	sample_held: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		sample_valid && !sample_ready |=> sample_valid && $stable(sample_data))
		else $error("sample dropped or changed while sample_ready low");

endmodule

bind adc_display_top adc_display_assert checks (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.sample_valid (sample_valid),
	.sample_ready (sample_ready),
	.sample_data  (sample_data),
	.seg_number   (seg_number),
	.seg_choice   (seg_choice)
);

`default_nettype wire

//--- bench/adc_display_tb.sv
/*
 * directed testbench for the converter value display path
 * sends samples, decodes the scanned segments back into a frame and compares
 */
`default_nettype none

`include "disp_settings.svh"

module adc_display_tb
	import disp_num_pkg::*;
	import seg_glyph_pkg::*;
();

	localparam int clk_period     = 40;
	localparam int reset_cycles   = 10;
	localparam int settle_cycles  = 16;    // transfer to new frame is 11
	localparam int random_count   = 40;
	localparam int burst_count    = 5;
	localparam int timeout_cycles = 4000;  // summed test length is about 2600 cycles

	// marker code f on digit 7 and blank code a on the seven below
	localparam glyph_frame_t idle_exp = 32'hfaaa_aaaa;

	logic                    sys_clk;
	logic                    sys_rst_n;
	logic                    sample_valid;
	logic                    sample_ready;
	sample_t                 sample_data;
	seg_pattern_t            seg_number;
	logic [`DISP_DIGITS-1:0] seg_choice;

	int     cycle_cnt = 0;
	int     xfer_cnt = 0;    // taken at the falling edge before each transfer
	integer seed;

	adc_display_top UUT (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.sample_valid (sample_valid),
		.sample_ready (sample_ready),
		.sample_data  (sample_data),
		.seg_number   (seg_number),
		.seg_choice   (seg_choice)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(clk_period / 2) sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles)
			abort_run($sformatf("timeout, run still going after %0d cycles", cycle_cnt));
	end

	always @(negedge sys_clk) begin
		if (sys_rst_n && sample_valid && sample_ready)
			xfer_cnt <= xfer_cnt + 1;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// frame the display should show for a sample
	function automatic glyph_frame_t expect_frame(input sample_t v);
		int           hund;
		int           tens;
		glyph_frame_t f;
		hund = int'(v) / 100;
		tens = (int'(v) / 10) % 10;
		f = idle_exp;
		f[0] = glyph_code_t'(int'(v) % 10);
		if (hund != 0 || tens != 0)
			f[1] = glyph_code_t'(tens);
		if (hund != 0)
			f[2] = glyph_code_t'(hund);
		return f;
	endfunction

	// glyph code behind a segment byte or -1
	function automatic int code_of(input seg_pattern_t seg);
		for (int c = 0; c < 16; c++) begin
			if (glyph_segments(glyph_code_t'(c)) == seg)
				return c;
		end
		return -1;
	endfunction

	function automatic int selected_digit(input logic [`DISP_DIGITS-1:0] sel);
		int idx;
		int zeros;
		idx = -1;
		zeros = 0;
		for (int i = 0; i < `DISP_DIGITS; i++) begin
			if (sel[i] == 1'b0) begin
				idx = i;
				zeros++;
			end
		end
		return (zeros == 1) ? idx : -1;
	endfunction

	task automatic send_sample(input sample_t v);
		@(posedge sys_clk);
		sample_valid <= 1'b1;
		sample_data  <= v;
		@(negedge sys_clk);
		while (!sample_ready)
			@(negedge sys_clk);
		@(posedge sys_clk);    // taken on this edge
		sample_valid <= 1'b0;
	endtask

	// wait for the input slice to free up and the result to reach the frame
	task automatic wait_idle();
		@(negedge sys_clk);
		while (!sample_ready)
			@(negedge sys_clk);
		repeat (settle_cycles) @(posedge sys_clk);
	endtask

	task automatic read_frame(output glyph_frame_t f);
		logic [`DISP_DIGITS-1:0] seen;
		int                      idx;
		int                      code;
		seen = '0;
		f = '0;
		while (seen != '1) begin
			@(negedge sys_clk);
			idx = selected_digit(seg_choice);
			code = code_of(seg_number);
			if (idx < 0)
				abort_run($sformatf("seg_choice 0x%h does not select one digit", seg_choice));
			else if (code < 0)
				abort_run($sformatf("segment byte 0x%h is no known glyph", seg_number));
			else begin
				f[idx] = glyph_code_t'(code);
				seen[idx] = 1'b1;
			end
		end
	endtask

	task automatic show_and_check(input sample_t v);
		glyph_frame_t got;
		send_sample(v);
		wait_idle();
		read_frame(got);
		check($sformatf("frame for %0d", v), got, expect_frame(v));
	endtask

	task automatic test_reset_state();
		glyph_frame_t got;
		@(negedge sys_clk);
		check("seg_choice", 32'(seg_choice), 32'h0000_00fe);
		check("sample_ready", 32'(sample_ready), 32'd1);
		read_frame(got);
		check("frame", got, idle_exp);
	endtask

	task automatic test_edge_values();
		sample_t vals[6] = '{8'd0, 8'd7, 8'd10, 8'd99, 8'd100, 8'd255};
		foreach (vals[i])
			show_and_check(vals[i]);
	endtask

	task automatic test_random_values();
		for (int n = 0; n < random_count; n++)
			show_and_check(sample_t'($random(seed)));
	endtask

	// valid held high over the whole burst
	task automatic test_back_pressure();
		sample_t      vals[burst_count];
		int           start_cnt;
		int           low_cycles;
		glyph_frame_t got;
		foreach (vals[i])
			vals[i] = sample_t'($random(seed));
		start_cnt = xfer_cnt;
		low_cycles = 0;
		@(posedge sys_clk);
		sample_valid <= 1'b1;
		sample_data  <= vals[0];
		for (int i = 0; i < burst_count; i++) begin
			@(negedge sys_clk);
			while (!sample_ready) begin
				low_cycles++;
				@(negedge sys_clk);
			end
			@(posedge sys_clk);
			if (i + 1 < burst_count)
				sample_data <= vals[i + 1];
			else
				sample_valid <= 1'b0;
		end
		wait_idle();
		check("sample transfers", 32'(xfer_cnt - start_cnt), 32'(burst_count));
		if (low_cycles == 0)
			abort_run("sample_ready never went low during the burst");
		read_frame(got);
		check("frame after burst", got, expect_frame(vals[burst_count-1]));
	endtask

	task automatic test_scan_order();
		int prev;
		int idx;
		int hold;
		@(negedge sys_clk);
		prev = selected_digit(seg_choice);
		idx = prev;
		while (idx == prev) begin    // line up on a digit change
			@(negedge sys_clk);
			idx = selected_digit(seg_choice);
		end
		for (int s = 0; s < 2 * `DISP_DIGITS; s++) begin
			check("scan digit", 32'(idx), 32'((prev + 1) % `DISP_DIGITS));
			prev = idx;
			hold = 0;
			while (idx == prev) begin
				hold++;
				@(negedge sys_clk);
				idx = selected_digit(seg_choice);
			end
			check("scan hold cycles", 32'(hold), 32'(`DISP_SCAN_DIV));
		end
	endtask

	initial begin
		seed = 24407;
		sys_rst_n = 1'b0;
		sample_valid = 1'b0;
		sample_data = '0;
		repeat (reset_cycles) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		test_reset_state();
		test_edge_values();
		test_random_values();
		test_back_pressure();
		test_scan_order();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the display path with its testbench and run it under Verilator
# a $fatal or a failed assertion gives a non-zero exit status
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
	--top-module adc_display_tb \
	-f adc_display.f \
	-o adc_display_sim

./obj_dir/adc_display_sim

//--- verilog/adc_display_top.sv
/*
 * converter value display path
 * sample slice, BCD converter, result slice, formatter, scanner
 */
`default_nettype none

`include "disp_settings.svh"

module adc_display_top
	import disp_num_pkg::*;
	import seg_glyph_pkg::*;
(
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    sample_valid,
	output logic                    sample_ready,
	input  sample_t                 sample_data,
	output seg_pattern_t            seg_number,
	output logic [`DISP_DIGITS-1:0] seg_choice
);

	logic         slice_valid;
	sample_t      slice_data;
	logic         conv_ready;
	logic         bcd_valid;
	bcd_value_t   bcd_data;
	logic         bcd_ready;
	logic         fmt_valid;
	bcd_value_t   fmt_data;
	glyph_frame_t frame;

	pipe_slice #(.payload_t(sample_t)) in_slice (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.in_valid  (sample_valid),
		.in_ready  (sample_ready),
		.in_data   (sample_data),
		.out_valid (slice_valid),
		.out_ready (conv_ready),
		.out_data  (slice_data)
	);

	bin_to_bcd conv (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.in_valid  (slice_valid),
		.in_ready  (conv_ready),
		.in_data   (slice_data),
		.out_valid (bcd_valid),
		.out_ready (bcd_ready),
		.out_data  (bcd_data)
	);

	// formatter takes every result, no back-pressure past here
	pipe_slice #(.payload_t(bcd_value_t)) out_slice (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.in_valid  (bcd_valid),
		.in_ready  (bcd_ready),
		.in_data   (bcd_data),
		.out_valid (fmt_valid),
		.out_ready (1'b1),
		.out_data  (fmt_data)
	);

	digit_format fmt (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.in_valid  (fmt_valid),
		.in_data   (fmt_data),
		.frame     (frame)
	);

	seg_scan scan (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.frame      (frame),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

endmodule

`default_nettype wire

//--- verilog/bin_to_bcd.sv
/*
 * iterative binary to BCD converter, shift and add three
 * one bit per cycle, result held until the consumer takes it
 */
`default_nettype none

`include "disp_settings.svh"

module bin_to_bcd import disp_num_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       in_valid,
	output logic       in_ready,
	input  sample_t    in_data,
	output logic       out_valid,
	input  logic       out_ready,
	output bcd_value_t out_data
);

	localparam int cnt_w = $clog2(`DISP_SAMPLE_W + 1);

	sample_t          bin_sr;     // binary bits still to shift in
	bcd_value_t       bcd_sr;     // digits being built
	bcd_value_t       bcd_adj;
	logic [cnt_w-1:0] bit_cnt;
	logic             busy;
	logic             in_take;

	// ready from state only: idle and nothing waiting at the output
	assign in_ready = !busy && !out_valid;
	assign in_take  = in_valid && in_ready;
	assign out_data = bcd_sr;

	// add three to any digit of five or more before the shift
	always_comb begin
		for (int i = 0; i < `DISP_BCD_DIGITS; i++) begin
			if (bcd_sr[i] >= 4'd5)
				bcd_adj[i] = bcd_sr[i] + 4'd3;
			else
				bcd_adj[i] = bcd_sr[i];
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy      <= 1'b0;
			bit_cnt   <= '0;
			out_valid <= 1'b0;
		end else begin
			if (in_take) begin
				busy    <= 1'b1;
				bit_cnt <= cnt_w'(`DISP_SAMPLE_W);
			end else if (busy) begin
				bit_cnt <= bit_cnt - 1'b1;
				if (bit_cnt == cnt_w'(1)) begin  // last bit goes in now
					busy      <= 1'b0;
					out_valid <= 1'b1;
				end
			end
			if (out_valid && out_ready)
				out_valid <= 1'b0;
		end
	end

	// datapath
	always_ff @(posedge sys_clk) begin
		if (in_take) begin
			bin_sr <= in_data;
			bcd_sr <= '0;
		end else if (busy) begin
			{bcd_sr, bin_sr} <= {bcd_adj, bin_sr} << 1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/digit_format.sv
/*
 * display frame formatter
 * places ones, tens and hundreds with leading zeros blanked
 * and the channel marker on the leftmost digit
 */
`default_nettype none

`include "disp_settings.svh"

module digit_format
	import disp_num_pkg::*;
	import seg_glyph_pkg::*;
(
	input  logic         sys_clk,
	input  logic         sys_rst_n,
	input  logic         in_valid,
	input  bcd_value_t   in_data,
	output glyph_frame_t frame
);

	// marker left, everything else dark
	localparam glyph_frame_t idle_frame =
		{GLYPH_MARK, {(`DISP_DIGITS-1){GLYPH_BLANK}}};

	glyph_frame_t next_frame;
	logic         hund_zero;
	logic         tens_zero;

	assign hund_zero = (in_data[bcd_hund] == 4'd0);
	assign tens_zero = (in_data[bcd_tens] == 4'd0);

	always_comb begin
		next_frame = idle_frame;
		next_frame[0] = glyph_code_t'(in_data[bcd_ones]);   // ones always shown
		if (!hund_zero || !tens_zero)
			next_frame[1] = glyph_code_t'(in_data[bcd_tens]);
		if (!hund_zero)
			next_frame[2] = glyph_code_t'(in_data[bcd_hund]);
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			frame <= idle_frame;
		end else if (in_valid) begin
			frame <= next_frame;
		end
	end

endmodule

`default_nettype wire

//--- verilog/disp_num_pkg.sv
/*
 * numeric types of the display path
 * raw converter samples and the decimal digits made from them
 */
`default_nettype none

`include "disp_settings.svh"

package disp_num_pkg;

	// unsigned converter word
	typedef logic [`DISP_SAMPLE_W-1:0] sample_t;

	// one decimal digit, 0 to 9
	typedef logic [3:0] bcd_digit_t;

	// hundreds, tens, ones as one packed group
	typedef bcd_digit_t [`DISP_BCD_DIGITS-1:0] bcd_value_t;

	// positions inside bcd_value_t
	localparam int bcd_ones = 0;
	localparam int bcd_tens = 1;
	localparam int bcd_hund = 2;

endpackage

`default_nettype wire

//--- verilog/disp_settings.svh
/*
 * display path settings
 * sample width, digit counts and scan timing shared by packages and RTL
 */
`ifndef DISP_SETTINGS_SVH
`define DISP_SETTINGS_SVH

// converter sample, one unsigned byte
`define DISP_SAMPLE_W 8

// decimal digits out of the converter
// 255 needs hundreds, tens and ones
`define DISP_BCD_DIGITS 3

// digits on the seven-segment module
`define DISP_DIGITS 8

// bits to index one display digit
`define DISP_DIGIT_IDX_W 3

// cycles each digit stays selected
// kept short for simulation, raise for the board clock
`define DISP_SCAN_DIV 4

// prescale counter width, must hold DISP_SCAN_DIV - 1
`define DISP_SCAN_CNT_W 2

`endif

//--- verilog/pipe_slice.sv
/*
 * one-entry register slice on a valid/ready link
 * payload type is a parameter so one slice serves samples and BCD digits
 */
`default_nettype none

module pipe_slice #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     sys_clk,
	input  logic     sys_rst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic in_take;
	logic out_take;

	// free slot, or the held word leaves this cycle
	assign in_ready = !out_valid || out_ready;
	assign in_take  = in_valid && in_ready;
	assign out_take = out_valid && out_ready;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			out_valid <= 1'b0;
		end else if (in_take) begin
			out_valid <= 1'b1;    // refill wins over drain
		end else if (out_take) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (in_take)
			out_data <= in_data;
	end

endmodule

`default_nettype wire

//--- verilog/seg_glyph_pkg.sv
/*
 * glyph codes and segment patterns for the seven-segment module
 * segments are active low, bit 7 is the decimal point
 */
`default_nettype none

`include "disp_settings.svh"

package seg_glyph_pkg;

	typedef logic [3:0] glyph_code_t;       // 0..9 numerals, others special
	typedef glyph_code_t [`DISP_DIGITS-1:0] glyph_frame_t; // index 0 rightmost
	typedef logic [7:0] seg_pattern_t;      // dp, g..a, low lights

	localparam glyph_code_t GLYPH_BLANK = 4'd10;
	localparam glyph_code_t GLYPH_MARK  = 4'd15; // channel marker, letter A

	// decimal point stays dark in every pattern
	function automatic seg_pattern_t glyph_segments(input glyph_code_t code);
		case (code)
			4'd0:       return 8'hc0;
			4'd1:       return 8'hf9;
			4'd2:       return 8'ha4;
			4'd3:       return 8'hb0;
			4'd4:       return 8'h99;
			4'd5:       return 8'h92;
			4'd6:       return 8'h82;
			4'd7:       return 8'hf8;
			4'd8:       return 8'h80;
			4'd9:       return 8'h90;
			GLYPH_MARK: return 8'h88;   // segments a b c e f g
			default:    return 8'hff;   // blank and unused codes
		endcase
	endfunction

endpackage

`default_nettype wire

//--- verilog/seg_scan.sv
/*
 * seven-segment digit scanner
 * walks digit 0 to 7, one active-low select at a time,
 * and drives the segments of the selected glyph
 */
`default_nettype none

`include "disp_settings.svh"

module seg_scan import seg_glyph_pkg::*; (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  glyph_frame_t            frame,
	output seg_pattern_t            seg_number,
	output logic [`DISP_DIGITS-1:0] seg_choice
);

	localparam int div_w    = `DISP_SCAN_CNT_W;
	localparam int idx_w    = `DISP_DIGIT_IDX_W;
	localparam int digits_w = `DISP_DIGITS;

	logic [div_w-1:0] div_cnt;    // prescale
	logic [idx_w-1:0] digit_idx;
	logic             step;

	assign step = (div_cnt == div_w'(`DISP_SCAN_DIV - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			div_cnt <= '0;
		end else if (step) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			digit_idx <= '0;
		end else if (step) begin
			if (digit_idx == idx_w'(`DISP_DIGITS - 1))
				digit_idx <= '0;    // wrap after the marker digit
			else
				digit_idx <= digit_idx + 1'b1;
		end
	end

	// both outputs come from the same index, so they switch together
	// frame is read live, a new value may land mid-scan
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			seg_choice <= {{(`DISP_DIGITS-1){1'b1}}, 1'b0};
			seg_number <= glyph_segments(GLYPH_BLANK);
		end else begin
			seg_choice <= ~(digits_w'(1) << digit_idx);
			seg_number <= glyph_segments(frame[digit_idx]);
		end
	end

endmodule

`default_nettype wire
